/* data_lane_array.f */
+incdir+include
hw/spad_route_pkg.sv
hw/route_csr_pkg.sv
hw/route_csr_axil.sv
hw/spad_stream_feeder.sv
hw/data_lane.sv
hw/lane_skew_drain.sv
hw/data_lane_array.sv
verification/data_lane_array_tb.sv

/* hw/data_lane.sv */
`timescale 1ns/1ps
`default_nettype none

module data_lane #(
    parameter int MISO_DEPTH = 16
) (
    input  logic i_clk,
    input  logic i_nrst,
    input  logic i_reg_clear,
    input  logic i_fifo_ptr_reset,
    input  logic i_ac_en,

    input  logic [spad_route_pkg::ADDR_WIDTH-1:0] i_start_addr,
    input  logic [spad_route_pkg::ADDR_WIDTH-1:0] i_end_addr,

    input  spad_route_pkg::spad_word_t i_data,
    input  logic [spad_route_pkg::ADDR_WIDTH-1:0] i_addr,
    input  logic i_data_valid,

    input  spad_route_pkg::p_mode_t i_p_mode,
    input  logic i_miso_pop_en,

    output logic [spad_route_pkg::DATA_WIDTH-1:0] o_data,
    output logic o_valid,
    output logic o_miso_empty,
    output logic o_miso_full,
    output logic o_route_done
);
    localparam int PW = $clog2(MISO_DEPTH);
    localparam int IW = $clog2(spad_route_pkg::SPAD_N4);
    localparam int DW = spad_route_pkg::DATA_WIDTH;

    spad_route_pkg::spad_word_t mem [MISO_DEPTH];
    spad_route_pkg::spad_word_t head;
    logic [PW-1:0] wr_ptr, rd_ptr;
    logic [PW:0] count;
    logic [IW-1:0] idx, last;
    logic [DW-1:0] elem;
    logic in_win, push, pop, retire;

    function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] p);
        return (p == PW'(MISO_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    // ******************************************************************
    // Window compare and MISO FIFO
    // ******************************************************************
    assign in_win = (i_addr >= i_start_addr) && (i_addr <= i_end_addr); // Bounds included.
    assign push = i_ac_en && i_data_valid && in_win && !i_fifo_ptr_reset;

    assign o_miso_empty = (count == '0);
    assign o_miso_full = (count >= (PW + 1)'(MISO_DEPTH - 1)); // Under 2 free.

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else if (i_fifo_ptr_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) wr_ptr <= next_ptr(wr_ptr);
            if (retire) rd_ptr <= next_ptr(rd_ptr);
            if (push && !retire) count <= count + 1'b1;
            else if (retire && !push) count <= count - 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (push) mem[wr_ptr] <= i_data;
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) o_route_done <= 1'b0;
        else if (i_reg_clear) o_route_done <= 1'b0;
        else if (i_ac_en && i_data_valid && i_addr == i_end_addr) o_route_done <= 1'b1;
    end

    // ******************************************************************
    // Element unpacker
    // ******************************************************************
    assign head = mem[rd_ptr];
    assign last = (i_p_mode == spad_route_pkg::PM_INT4) ? IW'(spad_route_pkg::SPAD_N4 - 1)
                                                         : IW'(spad_route_pkg::SPAD_N - 1);
    assign pop = i_miso_pop_en && !o_miso_empty && !i_reg_clear && !i_fifo_ptr_reset;
    assign retire = pop && (idx >= last); // Mode may change mid-word.

    always_comb begin
        if (i_p_mode == spad_route_pkg::PM_INT4) elem = {{(DW - 4){1'b0}}, head.nibbles[idx]};
        else elem = head.bytes[idx[IW-2:0]];
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            idx <= '0;
            o_valid <= 1'b0;
        end else begin
            o_valid <= pop;
            if (i_reg_clear || i_fifo_ptr_reset || retire) idx <= '0;
            else if (pop) idx <= idx + 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (pop) o_data <= elem;
    end

    a_no_overflow: assert property (@(posedge i_clk) disable iff (!i_nrst)
        push |-> count != (PW + 1)'(MISO_DEPTH));

endmodule

`default_nettype wire

/* hw/data_lane_array.sv */
`timescale 1ns/1ps
`default_nettype none

module data_lane_array #(
    parameter int COUNT = 4,
    parameter int MISO_DEPTH = 16
) (
    input  logic i_clk,
    input  logic i_nrst,

    // AXI4-Lite.
    input  logic [route_csr_pkg::AXIL_ADDR_WIDTH-1:0] i_awaddr,
    input  logic i_awvalid,
    output logic o_awready,
    input  logic [route_csr_pkg::AXIL_DATA_WIDTH-1:0] i_wdata,
    input  logic [route_csr_pkg::AXIL_DATA_WIDTH/8-1:0] i_wstrb,
    input  logic i_wvalid,
    output logic o_wready,
    output logic [1:0] o_bresp,
    output logic o_bvalid,
    input  logic i_bready,
    input  logic [route_csr_pkg::AXIL_ADDR_WIDTH-1:0] i_araddr,
    input  logic i_arvalid,
    output logic o_arready,
    output logic [route_csr_pkg::AXIL_DATA_WIDTH-1:0] o_rdata,
    output logic [1:0] o_rresp,
    output logic o_rvalid,
    input  logic i_rready,

    // Scratchpad stream.
    input  logic i_spad_valid,
    input  spad_route_pkg::spad_word_t i_spad_data,
    input  logic [spad_route_pkg::ADDR_WIDTH-1:0] i_spad_addr,
    output logic o_spad_ready,

    input  logic i_pop_en,

    output logic [COUNT-1:0][spad_route_pkg::DATA_WIDTH-1:0] o_data,
    output logic [COUNT-1:0] o_data_valid,
    output logic [COUNT-1:0] o_fifo_full,
    output logic o_fifo_empty,
    output logic o_route_done
);
    logic reg_clear, fifo_ptr_reset, ac_en;
    spad_route_pkg::p_mode_t p_mode;
    logic [COUNT-1:0][spad_route_pkg::ADDR_WIDTH-1:0] start_addr, end_addr;
    logic bc_valid;
    spad_route_pkg::spad_word_t bc_data;
    logic [spad_route_pkg::ADDR_WIDTH-1:0] bc_addr;
    logic [COUNT-1:0] lane_empty, lane_done, lane_pop_en;

    route_csr_axil #(.COUNT(COUNT)) u_csr (
        .i_clk(i_clk), .i_nrst(i_nrst),
        .i_awaddr(i_awaddr), .i_awvalid(i_awvalid), .o_awready(o_awready),
        .i_wdata(i_wdata), .i_wstrb(i_wstrb), .i_wvalid(i_wvalid), .o_wready(o_wready),
        .o_bresp(o_bresp), .o_bvalid(o_bvalid), .i_bready(i_bready),
        .i_araddr(i_araddr), .i_arvalid(i_arvalid), .o_arready(o_arready),
        .o_rdata(o_rdata), .o_rresp(o_rresp), .o_rvalid(o_rvalid), .i_rready(i_rready),
        .i_route_done(o_route_done), .i_fifo_empty(o_fifo_empty), .i_fifo_full(o_fifo_full),
        .o_reg_clear(reg_clear), .o_fifo_ptr_reset(fifo_ptr_reset),
        .o_ac_en(ac_en), .o_p_mode(p_mode),
        .o_start_addr(start_addr), .o_end_addr(end_addr)
    );

    spad_stream_feeder u_feeder (
        .i_clk(i_clk), .i_nrst(i_nrst),
        .i_spad_valid(i_spad_valid), .i_spad_data(i_spad_data),
        .i_spad_addr(i_spad_addr), .o_spad_ready(o_spad_ready),
        .i_any_full(|o_fifo_full),
        .o_bc_valid(bc_valid), .o_bc_data(bc_data), .o_bc_addr(bc_addr)
    );

    for (genvar k = 0; k < COUNT; k++) begin : g_lane
        data_lane #(.MISO_DEPTH(MISO_DEPTH)) u_lane (
            .i_clk(i_clk), .i_nrst(i_nrst),
            .i_reg_clear(reg_clear), .i_fifo_ptr_reset(fifo_ptr_reset), .i_ac_en(ac_en),
            .i_start_addr(start_addr[k]), .i_end_addr(end_addr[k]),
            .i_data(bc_data), .i_addr(bc_addr), .i_data_valid(bc_valid),
            .i_p_mode(p_mode), .i_miso_pop_en(lane_pop_en[k]),
            .o_data(o_data[k]), .o_valid(o_data_valid[k]),
            .o_miso_empty(lane_empty[k]), .o_miso_full(o_fifo_full[k]),
            .o_route_done(lane_done[k])
        );
    end

    lane_skew_drain #(.COUNT(COUNT)) u_drain (
        .i_clk(i_clk), .i_nrst(i_nrst),
        .i_reg_clear(reg_clear), .i_pop_en(i_pop_en),
        .i_lane_empty(lane_empty), .i_lane_done(lane_done),
        .o_pop_en(lane_pop_en), .o_fifo_empty(o_fifo_empty), .o_route_done(o_route_done)
    );

endmodule

`default_nettype wire

/* hw/lane_skew_drain.sv */
`timescale 1ns/1ps
`default_nettype none

module lane_skew_drain #(
    parameter int COUNT = 4
) (
    input  logic i_clk,
    input  logic i_nrst,
    input  logic i_reg_clear,
    input  logic i_pop_en,

    input  logic [COUNT-1:0] i_lane_empty,
    input  logic [COUNT-1:0] i_lane_done,

    output logic [COUNT-1:0] o_pop_en,
    output logic o_fifo_empty,
    output logic o_route_done
);
    localparam int CW = $clog2(COUNT + 1);

    logic [CW-1:0] skew_cnt; // Saturates at COUNT.

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) skew_cnt <= '0;
        else if (i_reg_clear) skew_cnt <= '0;
        else if (i_pop_en && skew_cnt != CW'(COUNT)) skew_cnt <= skew_cnt + 1'b1;
    end

    // Lane k joins k popping cycles after lane 0.
    always_comb begin
        for (int k = 0; k < COUNT; k++) begin
            o_pop_en[k] = i_pop_en && (int'(skew_cnt) >= k);
        end
    end

    assign o_fifo_empty = &i_lane_empty;
    assign o_route_done = &i_lane_done;

endmodule

`default_nettype wire

/* hw/route_csr_axil.sv */
`timescale 1ns/1ps
`default_nettype none

module route_csr_axil #(
    parameter int COUNT = 4
) (
    input  logic i_clk,
    input  logic i_nrst,

    input  logic [route_csr_pkg::AXIL_ADDR_WIDTH-1:0] i_awaddr,
    input  logic i_awvalid,
    output logic o_awready,
    input  logic [route_csr_pkg::AXIL_DATA_WIDTH-1:0] i_wdata,
    input  logic [route_csr_pkg::AXIL_DATA_WIDTH/8-1:0] i_wstrb,
    input  logic i_wvalid,
    output logic o_wready,
    output logic [1:0] o_bresp,
    output logic o_bvalid,
    input  logic i_bready,
    input  logic [route_csr_pkg::AXIL_ADDR_WIDTH-1:0] i_araddr,
    input  logic i_arvalid,
    output logic o_arready,
    output logic [route_csr_pkg::AXIL_DATA_WIDTH-1:0] o_rdata,
    output logic [1:0] o_rresp,
    output logic o_rvalid,
    input  logic i_rready,

    input  logic i_route_done,
    input  logic i_fifo_empty,
    input  logic [COUNT-1:0] i_fifo_full,

    output logic o_reg_clear,
    output logic o_fifo_ptr_reset,
    output logic o_ac_en,
    output spad_route_pkg::p_mode_t o_p_mode,
    output logic [COUNT-1:0][spad_route_pkg::ADDR_WIDTH-1:0] o_start_addr,
    output logic [COUNT-1:0][spad_route_pkg::ADDR_WIDTH-1:0] o_end_addr
);
    localparam int AW = route_csr_pkg::AXIL_ADDR_WIDTH;
    localparam int DW = route_csr_pkg::AXIL_DATA_WIDTH;
    localparam int LW = spad_route_pkg::ADDR_WIDTH;

    logic aw_got, w_got, aw_fire, w_fire, ar_fire, do_write;
    logic [AW-1:0] awaddr_q, wr_addr;
    logic [DW-1:0] wdata_q, wr_data, rd_data;
    logic [DW/8-1:0] wstrb_q, wr_strb;
    logic [1:0] rd_resp;

    function automatic logic is_win(input logic [AW-1:0] a);
        return (a >= route_csr_pkg::WIN_BASE) && (a < route_csr_pkg::WIN_BASE + 4 * COUNT);
    endfunction

    function automatic logic [AW-3:0] win_idx(input logic [AW-1:0] a);
        return a[AW-1:2] - route_csr_pkg::WIN_BASE[AW-1:2];
    endfunction

    // ******************************************************************
    // Write channel
    // ******************************************************************
    assign o_awready = !aw_got && !o_bvalid;
    assign o_wready = !w_got && !o_bvalid;
    assign aw_fire = i_awvalid && o_awready;
    assign w_fire = i_wvalid && o_wready;
    assign do_write = (aw_got || aw_fire) && (w_got || w_fire);

    assign wr_addr = aw_got ? awaddr_q : i_awaddr;
    assign wr_data = w_got ? wdata_q : i_wdata;
    assign wr_strb = w_got ? wstrb_q : i_wstrb;

    always_ff @(posedge i_clk) begin
        if (aw_fire) awaddr_q <= i_awaddr;
        if (w_fire) begin
            wdata_q <= i_wdata;
            wstrb_q <= i_wstrb;
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            aw_got <= 1'b0;
            w_got <= 1'b0;
            o_bvalid <= 1'b0;
            o_bresp <= route_csr_pkg::RESP_OKAY;
            o_reg_clear <= 1'b0;
            o_fifo_ptr_reset <= 1'b0;
            o_ac_en <= 1'b0;
            o_p_mode <= spad_route_pkg::PM_INT8;
            o_start_addr <= '0;
            o_end_addr <= '0;
        end else begin
            o_reg_clear <= 1'b0; // Pulses last one cycle.
            o_fifo_ptr_reset <= 1'b0;
            aw_got <= !do_write && (aw_got || aw_fire);
            w_got <= !do_write && (w_got || w_fire);
            if (o_bvalid && i_bready) o_bvalid <= 1'b0;
            if (do_write) begin
                o_bvalid <= 1'b1;
                o_bresp <= route_csr_pkg::RESP_OKAY;
                if (wr_addr == route_csr_pkg::CTRL_OFFSET) begin
                    if (wr_strb[0]) begin
                        o_reg_clear <= wr_data[route_csr_pkg::CTRL_CLEAR_BIT];
                        o_fifo_ptr_reset <= wr_data[route_csr_pkg::CTRL_PTR_RST_BIT];
                        o_ac_en <= wr_data[route_csr_pkg::CTRL_AC_EN_BIT];
                        o_p_mode <= spad_route_pkg::p_mode_t'(
                            wr_data[route_csr_pkg::CTRL_PMODE_LSB +: 2]);
                    end
                end else if (is_win(wr_addr)) begin
                    if (wr_strb[0]) o_start_addr[win_idx(wr_addr)] <= wr_data[0 +: LW];
                    if (wr_strb[1]) begin
                        o_end_addr[win_idx(wr_addr)] <=
                            wr_data[route_csr_pkg::WIN_END_LSB +: LW];
                    end
                end else if (wr_addr != route_csr_pkg::STATUS_OFFSET) begin
                    o_bresp <= route_csr_pkg::RESP_SLVERR;
                end
            end
        end
    end

    // ******************************************************************
    // Read channel
    // ******************************************************************
    assign o_arready = !o_rvalid;
    assign ar_fire = i_arvalid && o_arready;

    always_comb begin
        rd_data = '0;
        rd_resp = route_csr_pkg::RESP_OKAY;
        if (i_araddr == route_csr_pkg::CTRL_OFFSET) begin
            rd_data[route_csr_pkg::CTRL_AC_EN_BIT] = o_ac_en;
            rd_data[route_csr_pkg::CTRL_PMODE_LSB +: 2] = o_p_mode;
        end else if (i_araddr == route_csr_pkg::STATUS_OFFSET) begin
            rd_data[route_csr_pkg::STAT_DONE_BIT] = i_route_done;
            rd_data[route_csr_pkg::STAT_EMPTY_BIT] = i_fifo_empty;
            rd_data[route_csr_pkg::STAT_FULL_LSB +: COUNT] = i_fifo_full;
        end else if (is_win(i_araddr)) begin
            rd_data[0 +: LW] = o_start_addr[win_idx(i_araddr)];
            rd_data[route_csr_pkg::WIN_END_LSB +: LW] = o_end_addr[win_idx(i_araddr)];
        end else begin
            rd_resp = route_csr_pkg::RESP_SLVERR;
        end
    end

    always_ff @(posedge i_clk) begin
        if (ar_fire) begin
            o_rdata <= rd_data;
            o_rresp <= rd_resp;
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) o_rvalid <= 1'b0;
        else if (ar_fire) o_rvalid <= 1'b1;
        else if (i_rready) o_rvalid <= 1'b0;
    end

    a_bvalid_hold: assert property (@(posedge i_clk) disable iff (!i_nrst)
        o_bvalid && !i_bready |=> o_bvalid && $stable(o_bresp));

endmodule

`default_nettype wire

/* hw/route_csr_pkg.sv */
`default_nettype none

package route_csr_pkg;

    parameter int AXIL_ADDR_WIDTH = 8;
    parameter int AXIL_DATA_WIDTH = 32;

    parameter logic [AXIL_ADDR_WIDTH-1:0] CTRL_OFFSET = 8'h00;
    parameter logic [AXIL_ADDR_WIDTH-1:0] STATUS_OFFSET = 8'h04;
    parameter logic [AXIL_ADDR_WIDTH-1:0] WIN_BASE = 8'h10; // One word per lane.

    parameter logic [1:0] RESP_OKAY = 2'b00;
    parameter logic [1:0] RESP_SLVERR = 2'b10;

    // CTRL fields.
    parameter int CTRL_CLEAR_BIT = 0;
    parameter int CTRL_PTR_RST_BIT = 1;
    parameter int CTRL_AC_EN_BIT = 2;
    parameter int CTRL_PMODE_LSB = 4;

    // STATUS fields.
    parameter int STAT_DONE_BIT = 0;
    parameter int STAT_EMPTY_BIT = 1;
    parameter int STAT_FULL_LSB = 8;

    parameter int WIN_END_LSB = 8;

endpackage

`default_nettype wire

/* hw/spad_route_pkg.sv */
`default_nettype none

package spad_route_pkg;

    parameter int SPAD_DATA_WIDTH = 64;
    parameter int ADDR_WIDTH = 8;
    parameter int DATA_WIDTH = 8;
    parameter int SPAD_N = SPAD_DATA_WIDTH / DATA_WIDTH;
    parameter int SPAD_N4 = SPAD_DATA_WIDTH / 4;

    // Codes 2 and 3 are undefined and unpack like 8-bit mode.
    typedef enum logic [1:0] {
        PM_INT8 = 2'd0,
        PM_INT4 = 2'd1
    } p_mode_t;

    // Element 0 sits in the lowest bits in both views.
    typedef union packed {
        logic [SPAD_N-1:0][DATA_WIDTH-1:0] bytes;
        logic [SPAD_N4-1:0][3:0] nibbles;
    } spad_word_t;

endpackage

`default_nettype wire

/* hw/spad_stream_feeder.sv */
`timescale 1ns/1ps
`default_nettype none

module spad_stream_feeder (
    input  logic i_clk,
    input  logic i_nrst,

    input  logic i_spad_valid,
    input  spad_route_pkg::spad_word_t i_spad_data,
    input  logic [spad_route_pkg::ADDR_WIDTH-1:0] i_spad_addr,
    output logic o_spad_ready,

    input  logic i_any_full,

    output logic o_bc_valid,
    output spad_route_pkg::spad_word_t o_bc_data,
    output logic [spad_route_pkg::ADDR_WIDTH-1:0] o_bc_addr
);
    logic run; // Set once reset is released.
    logic xfer;

    assign o_spad_ready = run && !i_any_full;
    assign xfer = i_spad_valid && o_spad_ready;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            run <= 1'b0;
            o_bc_valid <= 1'b0;
        end else begin
            run <= 1'b1;
            o_bc_valid <= xfer;
        end
    end

    always_ff @(posedge i_clk) begin
        if (xfer) begin
            o_bc_data <= i_spad_data;
            o_bc_addr <= i_spad_addr;
        end
    end

    // A stalled word stays put while it is offered.
    a_src_stable: assert property (@(posedge i_clk) disable iff (!i_nrst)
        i_spad_valid && !o_spad_ready |=>
            !i_spad_valid || ($stable(i_spad_data) && $stable(i_spad_addr)));

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module data_lane_array_tb \
    -f data_lane_array.f \
    -o sim_data_lane_array

./obj_dir/sim_data_lane_array | tee sim.log

if grep -q "test failed" sim.log; then
    exit 1
fi
if ! grep -q "test passed" sim.log; then
    exit 1
fi
exit 0

/* include/tb_axil_tasks.svh */
`ifndef TB_AXIL_TASKS_SVH
`define TB_AXIL_TASKS_SVH

// ******************************************************************
// Typed compares
// ******************************************************************
task automatic check_elem(input string name,
                          input logic [spad_route_pkg::DATA_WIDTH-1:0] got,
                          input logic [spad_route_pkg::DATA_WIDTH-1:0] exp);
    if (got !== exp) begin
        stop_on_error($sformatf("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp));
    end
endtask

task automatic check_status(input string name,
                            input logic [route_csr_pkg::AXIL_DATA_WIDTH-1:0] got,
                            input logic [route_csr_pkg::AXIL_DATA_WIDTH-1:0] exp);
    if (got !== exp) begin
        stop_on_error($sformatf("FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp));
    end
endtask

task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
    if (got !== exp) begin
        stop_on_error($sformatf("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp));
    end
endtask

// ******************************************************************
// AXI4-Lite master
// ******************************************************************
task automatic axil_write(input logic [route_csr_pkg::AXIL_ADDR_WIDTH-1:0] addr,
                          input logic [route_csr_pkg::AXIL_DATA_WIDTH-1:0] data);
    bit aw_done;
    bit w_done;
    bit b_done;
    aw_done = 1'b0;
    w_done = 1'b0;
    b_done = 1'b0;
    i_awaddr <= addr;
    i_awvalid <= 1'b1;
    i_wdata <= data;
    i_wstrb <= '1;
    i_wvalid <= 1'b1;
    for (int t = 0; t < WAIT_LIMIT && !(aw_done && w_done); t++) begin
        @(posedge i_clk);
        if (!aw_done && o_awready) begin
            aw_done = 1'b1;
            i_awvalid <= 1'b0;
        end
        if (!w_done && o_wready) begin
            w_done = 1'b1;
            i_wvalid <= 1'b0;
        end
    end
    if (!(aw_done && w_done)) stop_on_error("AXI write address or data was never accepted");
    for (int t = 0; t < WAIT_LIMIT && !b_done; t++) begin
        @(posedge i_clk);
        if (o_bvalid) b_done = 1'b1; // bready is held high.
    end
    if (!b_done) stop_on_error("AXI write response never arrived");
    check_resp("o_bresp", o_bresp, route_csr_pkg::RESP_OKAY);
endtask

task automatic axil_read(input logic [route_csr_pkg::AXIL_ADDR_WIDTH-1:0] addr,
                         output logic [route_csr_pkg::AXIL_DATA_WIDTH-1:0] data,
                         output logic [1:0] resp);
    bit ar_done;
    bit r_done;
    ar_done = 1'b0;
    r_done = 1'b0;
    i_araddr <= addr;
    i_arvalid <= 1'b1;
    for (int t = 0; t < WAIT_LIMIT && !ar_done; t++) begin
        @(posedge i_clk);
        if (o_arready) begin
            ar_done = 1'b1;
            i_arvalid <= 1'b0;
        end
    end
    if (!ar_done) stop_on_error("AXI read address was never accepted");
    for (int t = 0; t < WAIT_LIMIT && !r_done; t++) begin
        @(posedge i_clk);
        if (o_rvalid) begin
            r_done = 1'b1;
            data = o_rdata;
            resp = o_rresp;
        end
    end
    if (!r_done) stop_on_error("AXI read data never arrived");
endtask

`endif

/* verification/data_lane_array_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module data_lane_array_tb;

    localparam int COUNT = 4;
    localparam int MISO_DEPTH = 16;
    localparam int DW = spad_route_pkg::DATA_WIDTH;
    localparam int AW = route_csr_pkg::AXIL_ADDR_WIDTH;
    localparam int RW = route_csr_pkg::AXIL_DATA_WIDTH;
    localparam int WAIT_LIMIT = 64;
    localparam int DRAIN_LIMIT = 4000;

    logic i_clk = 1'b0;
    logic i_nrst;
    logic [AW-1:0] i_awaddr;
    logic i_awvalid;
    logic o_awready;
    logic [RW-1:0] i_wdata;
    logic [RW/8-1:0] i_wstrb;
    logic i_wvalid;
    logic o_wready;
    logic [1:0] o_bresp;
    logic o_bvalid;
    logic i_bready;
    logic [AW-1:0] i_araddr;
    logic i_arvalid;
    logic o_arready;
    logic [RW-1:0] o_rdata;
    logic [1:0] o_rresp;
    logic o_rvalid;
    logic i_rready;
    logic i_spad_valid;
    spad_route_pkg::spad_word_t i_spad_data;
    logic [spad_route_pkg::ADDR_WIDTH-1:0] i_spad_addr;
    logic o_spad_ready;
    logic i_pop_en;
    logic [COUNT-1:0][DW-1:0] o_data;
    logic [COUNT-1:0] o_data_valid;
    logic [COUNT-1:0] o_fifo_full;
    logic o_fifo_empty;
    logic o_route_done;

    // Reference model state.
    integer seed = 55;
    logic [DW-1:0] exp_q [COUNT][$];
    logic [7:0] win_start [COUNT];
    logic [7:0] win_end [COUNT];
    bit lane_done [COUNT];
    logic [1:0] cur_mode;
    int pops_seen; // Popping cycles since the last clear.
    int first_valid [COUNT];
    int cycle;

    data_lane_array #(.COUNT(COUNT), .MISO_DEPTH(MISO_DEPTH)) i_dut (.*);

    always #10 i_clk = ~i_clk;

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("test failed");
        $fatal(1);
    endtask

    `include "tb_axil_tasks.svh"

    // ******************************************************************
    // Model
    // ******************************************************************
    function automatic void model_accept(input logic [7:0] addr, input logic [63:0] data);
        int n;
        n = (cur_mode == 2'd1) ? 16 : 8; // Codes 2 and 3 act as 8-bit.
        for (int k = 0; k < COUNT; k++) begin
            if (addr == win_end[k]) lane_done[k] = 1'b1;
            if (addr >= win_start[k] && addr <= win_end[k]) begin
                for (int i = 0; i < n; i++) begin
                    if (n == 16) exp_q[k].push_back(DW'((data >> (4 * i)) & 64'hF));
                    else exp_q[k].push_back(DW'((data >> (8 * i)) & 64'hFF));
                end
            end
        end
    endfunction

    function automatic bit model_empty();
        bit e;
        e = 1'b1;
        for (int k = 0; k < COUNT; k++) e &= (exp_q[k].size() == 0);
        return e;
    endfunction

    function automatic logic [RW-1:0] expected_status();
        logic [RW-1:0] s;
        bit all_done;
        int per_word;
        s = '0;
        all_done = 1'b1;
        per_word = (cur_mode == 2'd1) ? 16 : 8;
        for (int k = 0; k < COUNT; k++) begin
            all_done &= lane_done[k];
            s[route_csr_pkg::STAT_FULL_LSB + k] = (exp_q[k].size() / per_word) >= MISO_DEPTH - 1;
        end
        s[route_csr_pkg::STAT_DONE_BIT] = all_done;
        s[route_csr_pkg::STAT_EMPTY_BIT] = model_empty();
        return s;
    endfunction

    // ******************************************************************
    // Stimulus helpers
    // ******************************************************************
    task automatic write_ctrl(input bit clr, input bit ptr, input logic [1:0] mode);
        logic [RW-1:0] d;
        d = '0;
        d[route_csr_pkg::CTRL_CLEAR_BIT] = clr;
        d[route_csr_pkg::CTRL_PTR_RST_BIT] = ptr;
        d[route_csr_pkg::CTRL_AC_EN_BIT] = 1'b1;
        d[route_csr_pkg::CTRL_PMODE_LSB +: 2] = mode;
        axil_write(route_csr_pkg::CTRL_OFFSET, d);
        cur_mode = mode;
        for (int k = 0; k < COUNT; k++) begin
            if (ptr) exp_q[k].delete();
            if (clr) begin
                lane_done[k] = 1'b0;
                first_valid[k] = -1;
            end
        end
        if (clr) pops_seen = 0; // Skew counter restarts.
    endtask

    task automatic write_window(input int k, input logic [7:0] s, input logic [7:0] e);
        axil_write(route_csr_pkg::WIN_BASE + AW'(4 * k), {16'h0, e, s});
        win_start[k] = s;
        win_end[k] = e;
    endtask

    // Lane 1 overlaps lane 0, lane 3 is empty.
    task automatic set_route_windows();
        logic [7:0] s;
        s = 8'($random(seed) & 31);
        write_window(0, s, s + 8'd8 + 8'($random(seed) & 15));
        write_window(1, s + 8'd4, s + 8'd4 + 8'($random(seed) & 15));
        s = 8'($random(seed) & 31);
        write_window(2, s, s + 8'($random(seed) & 31));
        s = 8'($random(seed) & 31);
        write_window(3, s + 8'd1 + 8'($random(seed) & 7), s);
    endtask

    task automatic send_word(input logic [7:0] addr, input logic [63:0] data, output bit ok);
        ok = 1'b0;
        i_spad_valid <= 1'b1;
        i_spad_addr <= addr;
        i_spad_data <= data;
        for (int t = 0; t < WAIT_LIMIT && !ok; t++) begin
            @(posedge i_clk);
            if (o_spad_ready) begin
                ok = 1'b1;
                model_accept(addr, data);
            end
        end
    endtask

    task automatic send_random_words(input int n);
        bit ok;
        for (int i = 0; i < n; i++) begin
            send_word(8'($random(seed) & 63), {$random(seed), $random(seed)}, ok);
            if (!ok) stop_on_error("stream never accepted a word");
        end
        i_spad_valid <= 1'b0;
    endtask

    task automatic verify_status();
        logic [RW-1:0] d;
        logic [RW-1:0] want;
        logic [RW-1:0] ports;
        logic [1:0] r;
        axil_read(route_csr_pkg::STATUS_OFFSET, d, r);
        want = expected_status();
        check_resp("o_rresp", r, route_csr_pkg::RESP_OKAY);
        check_status("o_rdata (STATUS)", d, want);
        ports = '0;
        ports[route_csr_pkg::STAT_DONE_BIT] = o_route_done;
        ports[route_csr_pkg::STAT_EMPTY_BIT] = o_fifo_empty;
        ports[route_csr_pkg::STAT_FULL_LSB +: COUNT] = o_fifo_full;
        check_status("o_route_done, o_fifo_empty, o_fifo_full", ports, want);
    endtask

    task automatic drain_and_compare();
        bit done;
        write_ctrl(1'b1, 1'b0, cur_mode);
        i_pop_en <= 1'b1;
        done = 1'b0;
        for (int t = 0; t < DRAIN_LIMIT && !done; t++) begin
            @(negedge i_clk);
            done = model_empty();
        end
        @(posedge i_clk);
        i_pop_en <= 1'b0;
        if (!done) stop_on_error("lanes did not deliver all expected elements in time");
        for (int k = 1; k < COUNT; k++) begin
            if (first_valid[k] >= 0 && first_valid[k-1] >= 0 &&
                first_valid[k] < first_valid[k-1]) begin
                stop_on_error($sformatf("lane %0d started before lane %0d", k, k - 1));
            end
        end
        verify_status();
    endtask

    // Output checker; lane k may only pop once k earlier popping cycles passed.
    always @(posedge i_clk) begin
        if (i_nrst) begin
            for (int k = 0; k < COUNT; k++) begin
                if (o_data_valid[k]) begin
                    if (first_valid[k] < 0) first_valid[k] = cycle;
                    if (pops_seen <= k) begin
                        stop_on_error($sformatf("lane %0d popped ahead of its skew", k));
                    end else if (exp_q[k].size() == 0) begin
                        stop_on_error($sformatf("lane %0d output data nobody expected", k));
                    end else begin
                        check_elem($sformatf("o_data[%0d]", k), o_data[k], exp_q[k].pop_front());
                    end
                end
            end
            if (i_pop_en) pops_seen++;
            cycle++;
        end
    end

    initial begin
        logic [RW-1:0] rd;
        logic [1:0] rr;
        bit ok;
        int sent;
        i_nrst <= 1'b0;
        i_awaddr <= '0;
        i_awvalid <= 1'b0;
        i_wdata <= '0;
        i_wstrb <= '0;
        i_wvalid <= 1'b0;
        i_bready <= 1'b1;
        i_araddr <= '0;
        i_arvalid <= 1'b0;
        i_rready <= 1'b1;
        i_spad_valid <= 1'b0;
        i_spad_data <= '0;
        i_spad_addr <= '0;
        i_pop_en <= 1'b0;
        cur_mode = 2'd0;
        pops_seen = 0;
        cycle = 0;
        for (int k = 0; k < COUNT; k++) begin
            first_valid[k] = -1;
            lane_done[k] = 1'b0;
        end
        repeat (16) @(posedge i_clk);
        i_nrst <= 1'b1;
        @(posedge i_clk);

        // Register access.
        for (int k = 0; k < COUNT; k++) write_window(k, 8'($random(seed)), 8'($random(seed)));
        for (int k = 0; k < COUNT; k++) begin
            axil_read(route_csr_pkg::WIN_BASE + AW'(4 * k), rd, rr);
            check_resp("o_rresp", rr, route_csr_pkg::RESP_OKAY);
            check_status("o_rdata (WIN)", rd, {16'h0, win_end[k], win_start[k]});
        end
        write_ctrl(1'b0, 1'b0, 2'd2);
        axil_read(route_csr_pkg::CTRL_OFFSET, rd, rr);
        check_status("o_rdata (CTRL)", rd, (32'd1 << route_csr_pkg::CTRL_AC_EN_BIT) |
                                           (32'd2 << route_csr_pkg::CTRL_PMODE_LSB));
        axil_read(route_csr_pkg::WIN_BASE + AW'(4 * COUNT), rd, rr);
        check_resp("o_rresp", rr, route_csr_pkg::RESP_SLVERR);

        // 8-bit routing, then 4-bit routing.
        write_ctrl(1'b0, 1'b0, 2'd0);
        set_route_windows();
        send_random_words(12);
        drain_and_compare();
        write_ctrl(1'b0, 1'b0, 2'd1);
        set_route_windows();
        send_random_words(10);
        drain_and_compare();

        // Back-pressure with lane 0 taking every address.
        write_ctrl(1'b1, 1'b1, 2'd0);
        set_route_windows();
        write_window(0, 8'h00, 8'hFF);
        for (int k = 0; k < COUNT; k++) begin
            send_word(win_end[k], {$random(seed), $random(seed)}, ok);
            if (!ok) stop_on_error("stream never accepted an end-address word");
        end
        ok = 1'b1;
        sent = 0;
        while (ok && sent < 40) begin
            send_word(8'($random(seed)), {$random(seed), $random(seed)}, ok);
            sent++;
        end
        i_spad_valid <= 1'b0;
        if (ok) stop_on_error("o_spad_ready never fell while no lane was popped");
        verify_status();
        drain_and_compare();

        // Clear and pointer reset drop everything.
        send_random_words(6);
        write_ctrl(1'b1, 1'b1, 2'd0);
        verify_status();
        i_pop_en <= 1'b1;
        repeat (40) @(posedge i_clk);
        i_pop_en <= 1'b0;
        repeat (2) @(posedge i_clk);

        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire
